/* all.f */
+incdir+.
eth_frame_pkg.sv
eth_ctrl_pkg.sv
mac_tx.sv
eth_tx_framer.sv
rx_frame_capture.sv
rx_cmd_decoder.sv
eth_commu.sv
tb_eth_commu.sv

/* eth_commu.sv */
`include "eth_config.svh"

module eth_commu
	import eth_frame_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_rst_n,
	input  len_t        i_data_length,
	input  byte_t       i_cur_byte,
	input  logic        i_trig_send,
	output logic        o_feed_next_byte,
	output logic        o_send_over,
	output logic [15:0] o_cmd,
	output logic [31:0] o_param,
	output logic        o_cmd_come,
	input  logic        i_cmd_finish,
	output logic        o_eth_txen,
	output byte_t       o_eth_txd,
	input  logic        i_eth_rxdv,
	input  byte_t       i_eth_rxd
);
	logic mac_start;
	logic mac_take;
	logic mac_last;
	logic mac_done;
	byte_t mac_byte;
	logic arp_req;
	mac_addr_t arp_peer_mac;
	ip_addr_t arp_peer_ip;
	logic frame_done;
	byte_t [0:`ETH_CAPTURE_LEN-1] frame_bytes;

	eth_tx_framer eth_tx_framer_inst
	(
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_trig_send(i_trig_send),
		.i_data_length(i_data_length),
		.i_cur_byte(i_cur_byte),
		.i_arp_req(arp_req),
		.i_arp_peer_mac(arp_peer_mac),
		.i_arp_peer_ip(arp_peer_ip),
		.i_mac_take(mac_take),
		.i_mac_done(mac_done),
		.o_mac_start(mac_start),
		.o_mac_byte(mac_byte),
		.o_mac_last(mac_last),
		.o_feed_next_byte(o_feed_next_byte),
		.o_send_over(o_send_over)
	);

	mac_tx mac_tx_inst
	(
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_start(mac_start),
		.i_byte(mac_byte),
		.i_last(mac_last),
		.o_take(mac_take),
		.o_done(mac_done),
		.o_eth_txen(o_eth_txen),
		.o_eth_txd(o_eth_txd)
	);

	rx_frame_capture rx_frame_capture_inst
	(
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_eth_rxdv(i_eth_rxdv),
		.i_eth_rxd(i_eth_rxd),
		.o_frame_done(frame_done),
		.o_frame_bytes(frame_bytes)
	);

	rx_cmd_decoder rx_cmd_decoder_inst
	(
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_frame_done(frame_done),
		.i_frame_bytes(frame_bytes),
		.i_cmd_finish(i_cmd_finish),
		.o_cmd(o_cmd),
		.o_param(o_param),
		.o_cmd_come(o_cmd_come),
		.o_arp_req(arp_req),
		.o_arp_peer_mac(arp_peer_mac),
		.o_arp_peer_ip(arp_peer_ip)
	);

endmodule

/* eth_config.svh */
`ifndef ETH_CONFIG_SVH
`define ETH_CONFIG_SVH

// fixed station addresses
`define ETH_LOCAL_MAC 48'h02_00_00_00_00_04
`define ETH_LOCAL_IP 32'hC0_A8_01_04
`define ETH_DEST_MAC 48'h02_00_00_00_00_05
`define ETH_DEST_IP 32'hC0_A8_01_05
`define ETH_UDP_PORT 16'hFEEF

// frame geometry in bytes
`define ETH_MIN_PAYLOAD 18
`define ETH_HDR_LEN 42
`define ETH_CMD_LEN 8
`define ETH_CAPTURE_LEN 50

`define ETH_IP_TTL 8'd128
`define ETH_LEN_W 11

// preamble is 7 x 0x55 then the sfd
`define ETH_PREAMBLE_LEN 7
`define ETH_PREAMBLE_BYTE 8'h55
`define ETH_SFD_BYTE 8'hD5

`endif

/* eth_ctrl_pkg.sv */
package eth_ctrl_pkg;

	typedef enum logic [1:0]
	{
		TX_IDLE,
		TX_SEND_UDP,
		TX_SEND_ARP,
		TX_WAIT_DONE
	} tx_state_e;

	typedef enum logic [1:0]
	{
		MAC_IDLE,
		MAC_PREAMBLE,
		MAC_DATA,
		MAC_FCS
	} mac_state_e;

	typedef enum logic [2:0]
	{
		CAP_IDLE,
		CAP_CHECK_FRONT,
		CAP_STORE,
		CAP_ERROR,
		CAP_DONE
	} cap_state_e;

	typedef enum logic [1:0]
	{
		DEC_IDLE,
		DEC_CLASSIFY,
		DEC_WAIT_FINISH
	} dec_state_e;

endpackage

/* eth_frame_pkg.sv */
`include "eth_config.svh"

package eth_frame_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [47:0] mac_addr_t;
	typedef logic [31:0] ip_addr_t;
	typedef logic [`ETH_LEN_W-1:0] len_t;

	typedef enum logic [15:0]
	{
		ETYPE_IPV4 = 16'h0800,
		ETYPE_ARP  = 16'h0806
	} eth_type_e;

	typedef enum logic [15:0]
	{
		ARP_OP_REQUEST = 16'd1,
		ARP_OP_REPLY   = 16'd2
	} arp_op_e;

endpackage

/* eth_tests.txt */
# kind len cmd param target_ip dest_mac corrupt expect
# corrupt 1 spoils a preamble byte, corrupt 2 spoils the command check word
udp 18 0 0 0 0 0 1
udp 32 0 0 0 0 0 1
udp 5 0 0 0 0 0 1
udp 0 0 0 0 0 0 1
udp 1 0 0 0 0 0 1
udp 17 0 0 0 0 0 1
udp 19 0 0 0 0 0 1
cmd 0 1234 deadbeef 0 020000000004 0 1
cmd 0 00a5 00000001 0 ffffffffffff 0 1
bad 0 4321 cafef00d 0 020000000099 0 0
bad 0 5a5a 00001000 0 020000000004 1 0
bad 0 0f0f 87654321 0 020000000004 2 0
arp 0 0 0 c0a80104 ffffffffffff 0 1
arp 0 0 0 c0a80177 ffffffffffff 0 0
arp 0 0 0 c0a80104 020000000077 0 0
arp 0 0 0 c0a80104 020000000004 0 1
cmd 0 ffff 00000000 0 020000000004 0 1
udp 100 0 0 0 0 0 1

/* eth_tx_framer.sv */
`include "eth_config.svh"

module eth_tx_framer
	import eth_frame_pkg::*;
	import eth_ctrl_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_rst_n,
	input  logic      i_trig_send,
	input  len_t      i_data_length,
	input  byte_t     i_cur_byte,
	input  logic      i_arp_req,
	input  mac_addr_t i_arp_peer_mac,
	input  ip_addr_t  i_arp_peer_ip,
	input  logic      i_mac_take,
	input  logic      i_mac_done,
	output logic      o_mac_start,
	output byte_t     o_mac_byte,
	output logic      o_mac_last,
	output logic      o_feed_next_byte,
	output logic      o_send_over
);
	localparam int HDR_BITS = `ETH_HDR_LEN * 8;
	localparam logic [`ETH_LEN_W:0] HDR_LEN = `ETH_HDR_LEN;
	localparam byte_t IP_PROTO_UDP = 8'd17;
	localparam logic [15:0] IP_UDP_HDR_LEN = 16'd28;
	localparam logic [15:0] UDP_HDR_LEN = 16'd8;
	localparam ip_addr_t LOCAL_IP = `ETH_LOCAL_IP;
	localparam ip_addr_t DEST_IP = `ETH_DEST_IP;

	tx_state_e state;
	logic trig_d;
	logic send_pend;
	logic arp_pend;
	logic udp_frame;
	logic start_arp;
	logic start_udp;
	mac_addr_t peer_mac;
	ip_addr_t peer_ip;
	len_t data_len;
	len_t pad_len;
	len_t pad_len_w;
	logic [15:0] ip_total_len;
	logic [`ETH_LEN_W:0] idx;
	logic [`ETH_LEN_W:0] pay_idx;
	logic in_payload;
	logic [HDR_BITS-1:0] hdr_q;
	logic [HDR_BITS-1:0] hdr_shift;
	logic [HDR_BITS-1:0] udp_hdr;
	logic [HDR_BITS-1:0] arp_hdr;

	function automatic logic [15:0] ip_checksum(input logic [15:0] total_len);
		logic [31:0] sum;
		sum = 32'h0000_4500 + {16'h0, total_len} + {16'h0, `ETH_IP_TTL, IP_PROTO_UDP}
			+ {16'h0, LOCAL_IP[31:16]} + {16'h0, LOCAL_IP[15:0]}
			+ {16'h0, DEST_IP[31:16]} + {16'h0, DEST_IP[15:0]};
		sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]}; // fold carries
		sum = {16'h0, sum[15:0]} + {16'h0, sum[31:16]};
		return ~sum[15:0];
	endfunction

	assign start_arp = (state == TX_IDLE) && arp_pend; // arp reply goes first
	assign start_udp = (state == TX_IDLE) && !arp_pend && send_pend;

	assign pad_len_w = (i_data_length < len_t'(`ETH_MIN_PAYLOAD)) ?
		len_t'(`ETH_MIN_PAYLOAD) : i_data_length;
	assign ip_total_len = 16'(pad_len_w) + IP_UDP_HDR_LEN;

	// eth + ipv4 + udp, id/flags and udp checksum are zero
	assign udp_hdr = {`ETH_DEST_MAC, `ETH_LOCAL_MAC, ETYPE_IPV4,
		8'h45, 8'h00, ip_total_len, 16'h0000, 16'h0000,
		`ETH_IP_TTL, IP_PROTO_UDP, ip_checksum(ip_total_len), LOCAL_IP, DEST_IP,
		`ETH_UDP_PORT, `ETH_UDP_PORT, 16'(pad_len_w) + UDP_HDR_LEN, 16'h0000};

	assign arp_hdr = {peer_mac, `ETH_LOCAL_MAC, ETYPE_ARP,
		16'h0001, ETYPE_IPV4, 8'd6, 8'd4, ARP_OP_REPLY,
		`ETH_LOCAL_MAC, LOCAL_IP, peer_mac, peer_ip};

	assign in_payload = (idx >= HDR_LEN);
	assign pay_idx = idx - HDR_LEN;
	assign hdr_shift = hdr_q << {idx, 3'b000};

	assign o_feed_next_byte = (state == TX_SEND_UDP) && in_payload && (pay_idx < {1'b0, data_len});
	assign o_mac_byte = !in_payload ? hdr_shift[HDR_BITS-1 -: 8] :
		(o_feed_next_byte ? i_cur_byte : 8'h00);
	assign o_mac_last = (idx == HDR_LEN + {1'b0, pad_len} - 1'b1);

	always_ff @(posedge i_clk)
	begin
		if (i_arp_req)
		begin
			peer_mac <= i_arp_peer_mac;
			peer_ip <= i_arp_peer_ip;
		end
		if (start_arp)
		begin
			hdr_q <= arp_hdr;
			data_len <= '0;
			pad_len <= len_t'(`ETH_MIN_PAYLOAD); // 42 + 18 zeros gives the 60 byte arp frame
		end
		else if (start_udp)
		begin
			hdr_q <= udp_hdr;
			data_len <= i_data_length;
			pad_len <= pad_len_w;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			state <= TX_IDLE;
			trig_d <= 1'b0;
			send_pend <= 1'b0;
			arp_pend <= 1'b0;
			udp_frame <= 1'b0;
			idx <= '0;
			o_mac_start <= 1'b0;
			o_send_over <= 1'b0;
		end
		else
		begin
			trig_d <= i_trig_send;
			o_mac_start <= 1'b0;
			o_send_over <= 1'b0;
			case (state)
				TX_IDLE:
				begin
					idx <= '0;
					if (start_arp || start_udp)
					begin
						o_mac_start <= 1'b1;
						udp_frame <= start_udp;
						state <= start_arp ? TX_SEND_ARP : TX_SEND_UDP;
					end
					if (start_arp)
						arp_pend <= 1'b0;
					if (start_udp)
						send_pend <= 1'b0;
				end
				TX_SEND_UDP, TX_SEND_ARP:
				begin
					if (i_mac_take)
					begin
						idx <= idx + 1'b1;
						if (o_mac_last)
							state <= TX_WAIT_DONE;
					end
				end
				TX_WAIT_DONE:
				begin
					if (i_mac_done)
					begin
						state <= TX_IDLE;
						o_send_over <= udp_frame;
					end
				end
				default:
					state <= TX_IDLE;
			endcase
			// new requests win over the clear above
			if (i_trig_send && !trig_d)
				send_pend <= 1'b1;
			if (i_arp_req)
				arp_pend <= 1'b1;
		end
	end

endmodule

/* mac_tx.sv */
`include "eth_config.svh"

module mac_tx
	import eth_frame_pkg::*;
	import eth_ctrl_pkg::*;
(
	input  logic  i_clk,
	input  logic  i_rst_n,
	input  logic  i_start,
	input  byte_t i_byte,
	input  logic  i_last,
	output logic  o_take,
	output logic  o_done,
	output logic  o_eth_txen,
	output byte_t o_eth_txd
);
	localparam logic [2:0] SFD_POS = `ETH_PREAMBLE_LEN;

	mac_state_e state;
	logic [2:0] cnt;
	logic [31:0] crc;
	logic [31:0] fcs;

	// reflected crc-32, poly 0x04C11DB7
	function automatic logic [31:0] crc32_byte(input logic [31:0] crc_in, input byte_t data);
		logic [31:0] c;
		c = crc_in ^ {24'h0, data};
		for (int i = 0; i < 8; i++)
			c = c[0] ? ((c >> 1) ^ 32'hEDB88320) : (c >> 1);
		return c;
	endfunction

	assign fcs = ~crc;
	assign o_take = (state == MAC_DATA);
	assign o_eth_txen = (state != MAC_IDLE);

	always_comb
	begin
		case (state)
			MAC_PREAMBLE:
				o_eth_txd = (cnt == SFD_POS) ? `ETH_SFD_BYTE : `ETH_PREAMBLE_BYTE;
			MAC_DATA:
				o_eth_txd = i_byte;
			MAC_FCS:
				o_eth_txd = fcs[{cnt[1:0], 3'b000} +: 8]; // lsb first
			default:
				o_eth_txd = 8'h00;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			state <= MAC_IDLE;
			cnt <= '0;
			crc <= '1;
			o_done <= 1'b0;
		end
		else
		begin
			o_done <= 1'b0;
			case (state)
				MAC_IDLE:
				begin
					if (i_start)
					begin
						state <= MAC_PREAMBLE;
						cnt <= '0;
						crc <= '1;
					end
				end
				MAC_PREAMBLE:
				begin
					cnt <= cnt + 1'b1; // wraps to 0 after the sfd
					if (cnt == SFD_POS)
						state <= MAC_DATA;
				end
				MAC_DATA:
				begin
					crc <= crc32_byte(crc, i_byte);
					if (i_last)
					begin
						state <= MAC_FCS;
						cnt <= '0;
					end
				end
				MAC_FCS:
				begin
					cnt <= cnt + 1'b1;
					if (cnt == 3'd3)
					begin
						state <= MAC_IDLE;
						o_done <= 1'b1;
					end
				end
				default:
					state <= MAC_IDLE;
			endcase
		end
	end

endmodule

/* run.sh */
#!/usr/bin/env bash
# builds the eth_commu testbench with verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1
then
	echo "verilator not found in PATH"
	exit 1
fi

if ! verilator --binary --timing --assert -f all.f --top-module tb_eth_commu -Mdir obj_dir
then
	echo "build failed"
	exit 1
fi

if ! ./obj_dir/Vtb_eth_commu
then
	echo "simulation failed"
	exit 1
fi

echo "simulation finished"

/* rx_cmd_decoder.sv */
`include "eth_config.svh"

module rx_cmd_decoder
	import eth_frame_pkg::*;
	import eth_ctrl_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_rst_n,
	input  logic        i_frame_done,
	input  byte_t [0:`ETH_CAPTURE_LEN-1] i_frame_bytes,
	input  logic        i_cmd_finish,
	output logic [15:0] o_cmd,
	output logic [31:0] o_param,
	output logic        o_cmd_come,
	output logic        o_arp_req,
	output mac_addr_t   o_arp_peer_mac,
	output ip_addr_t    o_arp_peer_ip
);
	localparam int ETYPE_OFF = 12;
	localparam int ARP_OP_OFF = 20;
	localparam int ARP_SHA_OFF = 22;
	localparam int ARP_SPA_OFF = 28;
	localparam int ARP_TPA_OFF = 38;
	localparam int CMD_OFF = `ETH_HDR_LEN;
	localparam int PARAM_OFF = `ETH_HDR_LEN + `ETH_CMD_LEN - 4;

	dec_state_e state;
	mac_addr_t dst_mac;
	logic [15:0] eth_type;
	logic [15:0] arp_op;
	ip_addr_t arp_tpa;
	logic [15:0] cmd_word;
	logic [15:0] cmd_check;
	logic mac_ok;
	logic is_arp;
	logic is_cmd;
	logic cmd_busy;

	assign dst_mac = i_frame_bytes[0:5];
	assign eth_type = i_frame_bytes[ETYPE_OFF:ETYPE_OFF+1];
	assign arp_op = i_frame_bytes[ARP_OP_OFF:ARP_OP_OFF+1];
	assign arp_tpa = i_frame_bytes[ARP_TPA_OFF:ARP_TPA_OFF+3];
	assign cmd_word = i_frame_bytes[CMD_OFF:CMD_OFF+1];
	assign cmd_check = i_frame_bytes[CMD_OFF+2:CMD_OFF+3];

	assign mac_ok = (dst_mac == `ETH_LOCAL_MAC) || (&dst_mac); // own or broadcast
	assign is_arp = mac_ok && (eth_type == ETYPE_ARP) && (arp_op == ARP_OP_REQUEST)
		&& (arp_tpa == `ETH_LOCAL_IP);
	assign is_cmd = mac_ok && (eth_type == ETYPE_IPV4) && (cmd_word == ~cmd_check);
	assign cmd_busy = o_cmd_come && !i_cmd_finish;

	always_ff @(posedge i_clk)
	begin
		if (state == DEC_CLASSIFY && is_arp)
		begin
			o_arp_peer_mac <= i_frame_bytes[ARP_SHA_OFF:ARP_SHA_OFF+5];
			o_arp_peer_ip <= i_frame_bytes[ARP_SPA_OFF:ARP_SPA_OFF+3];
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			state <= DEC_IDLE;
			o_cmd <= '0;
			o_param <= '0;
			o_cmd_come <= 1'b0;
			o_arp_req <= 1'b0;
		end
		else
		begin
			o_arp_req <= 1'b0;
			if (o_cmd_come && i_cmd_finish)
				o_cmd_come <= 1'b0;
			case (state)
				DEC_IDLE, DEC_WAIT_FINISH:
				begin
					if (i_frame_done)
						state <= DEC_CLASSIFY;
					else if (!cmd_busy)
						state <= DEC_IDLE;
				end
				DEC_CLASSIFY:
				begin
					state <= cmd_busy ? DEC_WAIT_FINISH : DEC_IDLE;
					if (is_arp)
						o_arp_req <= 1'b1;
					else if (is_cmd && !o_cmd_come) // busy means the frame is dropped
					begin
						o_cmd <= cmd_word;
						o_param <= i_frame_bytes[PARAM_OFF:PARAM_OFF+3];
						o_cmd_come <= 1'b1;
						state <= DEC_WAIT_FINISH;
					end
				end
				default:
					state <= DEC_IDLE;
			endcase
		end
	end

endmodule

/* rx_frame_capture.sv */
`include "eth_config.svh"

module rx_frame_capture
	import eth_frame_pkg::*;
	import eth_ctrl_pkg::*;
(
	input  logic  i_clk,
	input  logic  i_rst_n,
	input  logic  i_eth_rxdv,
	input  byte_t i_eth_rxd,
	output logic  o_frame_done,
	output byte_t [0:`ETH_CAPTURE_LEN-1] o_frame_bytes
);
	localparam logic [5:0] CAP_LEN = `ETH_CAPTURE_LEN;
	localparam logic [2:0] SFD_POS = `ETH_PREAMBLE_LEN;

	cap_state_e state;
	logic [2:0] front_cnt;
	logic [5:0] wr_idx;
	logic front_ok;

	assign front_ok = (front_cnt == SFD_POS) ? (i_eth_rxd == `ETH_SFD_BYTE) :
		(i_eth_rxd == `ETH_PREAMBLE_BYTE);
	assign o_frame_done = (state == CAP_DONE);

	// bytes past the capture length are dropped
	always_ff @(posedge i_clk)
	begin
		if (state == CAP_STORE && i_eth_rxdv && wr_idx != CAP_LEN)
			o_frame_bytes[wr_idx] <= i_eth_rxd;
	end

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			state <= CAP_IDLE;
			front_cnt <= '0;
			wr_idx <= '0;
		end
		else
		begin
			front_cnt <= '0;
			case (state)
				CAP_IDLE:
				begin
					if (i_eth_rxdv)
					begin
						front_cnt <= 3'd1;
						state <= front_ok ? CAP_CHECK_FRONT : CAP_ERROR;
					end
				end
				CAP_CHECK_FRONT:
				begin
					if (!i_eth_rxdv)
						state <= CAP_IDLE;
					else if (!front_ok)
						state <= CAP_ERROR;
					else if (front_cnt == SFD_POS)
					begin
						state <= CAP_STORE;
						wr_idx <= '0;
					end
					else
						front_cnt <= front_cnt + 1'b1;
				end
				CAP_STORE:
				begin
					if (!i_eth_rxdv)
						state <= CAP_DONE;
					else if (wr_idx != CAP_LEN)
						wr_idx <= wr_idx + 1'b1;
				end
				CAP_ERROR:
				begin
					if (!i_eth_rxdv)
						state <= CAP_IDLE;
				end
				default:
					state <= CAP_IDLE; // done lasts one cycle
			endcase
		end
	end

endmodule

/* tb_eth_commu.sv */
`include "eth_config.svh"

module tb_eth_commu
	import eth_frame_pkg::*;
();
	localparam mac_addr_t PEER_MAC = 48'h02_00_00_00_00_09;
	localparam ip_addr_t PEER_IP = 32'hC0_A8_01_09;

	logic clk;
	logic rst_n;
	len_t data_length;
	byte_t cur_byte;
	logic trig_send;
	logic feed_next_byte;
	logic send_over;
	logic [15:0] cmd;
	logic [31:0] param;
	logic cmd_come;
	logic cmd_finish;
	logic eth_txen;
	byte_t eth_txd;
	logic eth_rxdv;
	byte_t eth_rxd;

	logic [31:0] lcg_state;
	byte_t build_q[$]; // frame being built, sent or expected
	byte_t payload[$];
	int feed_cnt;
	logic feed_seen;

	eth_commu eth_commu_inst
	(
		.i_clk(clk),
		.i_rst_n(rst_n),
		.i_data_length(data_length),
		.i_cur_byte(cur_byte),
		.i_trig_send(trig_send),
		.o_feed_next_byte(feed_next_byte),
		.o_send_over(send_over),
		.o_cmd(cmd),
		.o_param(param),
		.o_cmd_come(cmd_come),
		.i_cmd_finish(cmd_finish),
		.o_eth_txen(eth_txen),
		.o_eth_txd(eth_txd),
		.i_eth_rxdv(eth_rxdv),
		.i_eth_rxd(eth_rxd)
	);

	always #10 clk = ~clk;

	task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
		assert (exp == act)
		else
		begin
			$display("ERROR at %0t: %s expected %0h, got %0h", $time, name, exp, act);
			$display("test failed");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic timeout_fail(input string what);
		$display("timeout while waiting for %s", what);
		$display("test failed");
		$fatal(1, "no response from the DUT");
	endtask

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic rand_byte(output byte_t b);
		lcg_state = lcg_next(lcg_state);
		b = lcg_state[23:16];
	endtask

	task automatic put_bytes(input logic [47:0] v, input int n);
		for (int i = n - 1; i >= 0; i--)
			build_q.push_back(v[i*8 +: 8]); // network order
	endtask

	task automatic pad_to(input int n, input logic rnd);
		byte_t b;
		for (int i = build_q.size(); i < n; i++)
		begin
			b = 8'h00;
			if (rnd)
				rand_byte(b);
			build_q.push_back(b);
		end
	endtask

	// ones complement sum over the 20 byte ip header
	function automatic logic [15:0] ip_sum(input int first);
		logic [31:0] s;
		s = 32'h0;
		for (int i = first; i < first + 20; i += 2)
			s = s + {16'h0, build_q[i], build_q[i+1]};
		s = {16'h0, s[15:0]} + {16'h0, s[31:16]};
		s = {16'h0, s[15:0]} + {16'h0, s[31:16]};
		return ~s[15:0];
	endfunction

	function automatic logic [31:0] frame_crc();
		logic [31:0] r;
		logic fb;
		byte_t d;
		r = 32'hFFFF_FFFF;
		for (int i = 0; i < build_q.size(); i++)
		begin
			d = build_q[i];
			for (int b = 0; b < 8; b++)
			begin
				fb = r[0] ^ d[b];
				r = {1'b0, r[31:1]} ^ (fb ? 32'hEDB8_8320 : 32'h0);
			end
		end
		return ~r;
	endfunction

	task automatic wrap_frame(input logic bad_pre);
		logic [31:0] fcs;
		fcs = frame_crc();
		for (int i = 0; i < 4; i++)
			build_q.push_back(fcs[i*8 +: 8]); // lsb first on the wire
		build_q.push_front(`ETH_SFD_BYTE);
		for (int i = 0; i < 7; i++)
			build_q.push_front((bad_pre && i == 4) ? 8'h57 : `ETH_PREAMBLE_BYTE);
	endtask

	// one cycle, also hands the user payload to the DUT
	task automatic tick();
		@(posedge clk);
		if (feed_seen)
		begin
			feed_cnt++;
			if (feed_cnt < payload.size())
				cur_byte <= payload[feed_cnt];
		end
		@(negedge clk);
		feed_seen = feed_next_byte;
	endtask

	task automatic drive_rx();
		for (int i = 0; i < build_q.size(); i++)
		begin
			@(posedge clk);
			eth_rxdv <= 1'b1;
			eth_rxd <= build_q[i];
		end
		@(posedge clk);
		eth_rxdv <= 1'b0;
		eth_rxd <= 8'h00;
	endtask

	task automatic compare_tx_frame();
		int n;
		n = 0;
		tick();
		while (!eth_txen && n < 100)
		begin
			tick();
			n++;
		end
		if (!eth_txen)
			timeout_fail("o_eth_txen to rise");
		for (int i = 0; i < build_q.size(); i++)
		begin
			check("o_eth_txen", 64'd1, 64'(eth_txen));
			check("o_eth_txd", 64'(build_q[i]), 64'(eth_txd));
			tick();
		end
		check("o_eth_txen", 64'd0, 64'(eth_txen));
	endtask

	task automatic check_idle(input int cycles);
		for (int i = 0; i < cycles; i++)
		begin
			tick();
			check("o_eth_txen", 64'd0, 64'(eth_txen));
			check("o_cmd_come", 64'd0, 64'(cmd_come));
			check("o_send_over", 64'd0, 64'(send_over));
		end
	endtask

	task automatic send_udp(input int len);
		byte_t b;
		int padded;
		int n;
		logic [15:0] csum;
		padded = (len < `ETH_MIN_PAYLOAD) ? `ETH_MIN_PAYLOAD : len;
		payload.delete();
		for (int i = 0; i < len; i++)
		begin
			rand_byte(b);
			payload.push_back(b);
		end
		feed_cnt = 0;
		feed_seen = 1'b0;
		@(posedge clk);
		cur_byte <= (len > 0) ? payload[0] : 8'h00;
		data_length <= len_t'(len);
		trig_send <= 1'b1;
		@(posedge clk);
		trig_send <= 1'b0;

		build_q.delete();
		put_bytes(`ETH_DEST_MAC, 6);
		put_bytes(`ETH_LOCAL_MAC, 6);
		put_bytes(48'h0800, 2);
		put_bytes(48'h4500, 2);
		put_bytes(48'(padded + 28), 2);
		put_bytes(48'h0, 4); // id and fragment fields
		put_bytes(48'({`ETH_IP_TTL, 8'd17}), 2);
		put_bytes(48'h0, 2);
		put_bytes(48'(`ETH_LOCAL_IP), 4);
		put_bytes(48'(`ETH_DEST_IP), 4);
		csum = ip_sum(14);
		build_q[24] = csum[15:8];
		build_q[25] = csum[7:0];
		put_bytes(48'(`ETH_UDP_PORT), 2);
		put_bytes(48'(`ETH_UDP_PORT), 2);
		put_bytes(48'(padded + 8), 2);
		put_bytes(48'h0, 2);
		for (int i = 0; i < len; i++)
			build_q.push_back(payload[i]);
		pad_to(`ETH_HDR_LEN + padded, 1'b0);
		wrap_frame(1'b0);

		compare_tx_frame();
		check("o_feed_next_byte count", 64'(len), 64'(feed_cnt));
		n = 0;
		while (!send_over && n < 10)
		begin
			tick();
			n++;
		end
		if (!send_over)
			timeout_fail("o_send_over");
		tick();
		check("o_send_over", 64'd0, 64'(send_over));
	endtask

	task automatic rx_command(input logic [15:0] c, input logic [31:0] p,
		input mac_addr_t dmac, input int corrupt, input logic expect_come);
		int n;
		build_q.delete();
		put_bytes(dmac, 6);
		put_bytes(`ETH_DEST_MAC, 6);
		put_bytes(48'h0800, 2);
		pad_to(`ETH_HDR_LEN, 1'b1); // ip and udp headers are not checked
		put_bytes(48'(c), 2);
		put_bytes(48'((corrupt == 2) ? c : ~c), 2);
		put_bytes(48'(p), 4);
		pad_to(60, 1'b1);
		wrap_frame(corrupt == 1);
		drive_rx();
		if (expect_come)
		begin
			n = 0;
			while (!cmd_come && n < 10)
			begin
				tick();
				n++;
			end
			if (!cmd_come)
				timeout_fail("o_cmd_come");
			check("o_cmd", 64'(c), 64'(cmd));
			check("o_param", 64'(p), 64'(param));
			for (int i = 0; i < 3; i++)
			begin
				tick();
				check("o_cmd_come", 64'd1, 64'(cmd_come));
			end
			@(posedge clk);
			cmd_finish <= 1'b1;
			@(negedge clk);
			check("o_cmd_come", 64'd1, 64'(cmd_come));
			@(posedge clk);
			cmd_finish <= 1'b0;
			@(negedge clk);
			check("o_cmd_come", 64'd0, 64'(cmd_come));
			check_idle(10);
		end
		else
			check_idle(40);
	endtask

	task automatic rx_arp_request(input ip_addr_t tip, input mac_addr_t dmac,
		input logic expect_reply);
		build_q.delete();
		put_bytes(dmac, 6);
		put_bytes(PEER_MAC, 6);
		put_bytes(48'h0806, 2);
		put_bytes(48'h0001_0800_0604, 6); // htype, ptype, sizes
		put_bytes(48'h0001, 2);
		put_bytes(PEER_MAC, 6);
		put_bytes(48'(PEER_IP), 4);
		put_bytes(48'h0, 6);
		put_bytes(48'(tip), 4);
		pad_to(60, 1'b0);
		wrap_frame(1'b0);
		drive_rx();
		if (expect_reply)
		begin
			build_q.delete();
			put_bytes(PEER_MAC, 6);
			put_bytes(`ETH_LOCAL_MAC, 6);
			put_bytes(48'h0806, 2);
			put_bytes(48'h0001_0800_0604, 6);
			put_bytes(48'h0002, 2);
			put_bytes(`ETH_LOCAL_MAC, 6);
			put_bytes(48'(`ETH_LOCAL_IP), 4);
			put_bytes(PEER_MAC, 6);
			put_bytes(48'(PEER_IP), 4);
			pad_to(60, 1'b0);
			wrap_frame(1'b0);
			compare_tx_frame();
			check_idle(10);
		end
		else
			check_idle(40);
	endtask

	initial
	begin
		int fd;
		int cnt;
		int n_tests;
		logic [8*160-1:0] line;
		logic [23:0] kind;
		int len;
		logic [15:0] c;
		logic [31:0] p;
		logic [31:0] tip;
		logic [47:0] dmac;
		int corrupt;
		int expect_hit;

		clk = 1'b0;
		rst_n = 1'b0;
		data_length = '0;
		cur_byte = 8'h00;
		trig_send = 1'b0;
		cmd_finish = 1'b0;
		eth_rxdv = 1'b0;
		eth_rxd = 8'h00;
		lcg_state = 32'h2f0;
		feed_cnt = 0;
		feed_seen = 1'b0;
		n_tests = 0;

		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check("o_eth_txen", 64'd0, 64'(eth_txen));
		check("o_send_over", 64'd0, 64'(send_over));
		check("o_feed_next_byte", 64'd0, 64'(feed_next_byte));
		check("o_cmd_come", 64'd0, 64'(cmd_come));
		check("o_cmd", 64'd0, 64'(cmd));
		check("o_param", 64'd0, 64'(param));

		fd = $fopen("eth_tests.txt", "r");
		if (fd == 0)
		begin
			$display("could not open eth_tests.txt");
			$display("test failed");
			$fatal(1, "missing test data");
		end
		line = '0;
		while ($fgets(line, fd) != 0)
		begin
			cnt = $sscanf(line, "%s %d %h %h %h %h %d %d", kind, len, c, p, tip, dmac,
				corrupt, expect_hit);
			if (cnt == 8) // comment lines give fewer fields
			begin
				n_tests++;
				if (kind == "udp")
					send_udp(len);
				else if (kind == "cmd" || kind == "bad")
					rx_command(c, p, dmac, corrupt, expect_hit != 0);
				else if (kind == "arp")
					rx_arp_request(tip, dmac, expect_hit != 0);
				else
				begin
					$display("unknown test kind on a line of eth_tests.txt");
					$display("test failed");
					$fatal(1, "bad test data");
				end
			end
			line = '0;
		end
		$fclose(fd);

		if (n_tests == 0)
		begin
			$display("no test lines found in eth_tests.txt");
			$display("test failed");
			$fatal(1, "empty test data");
		end
		else
		begin
			$display("test passed");
			$finish;
		end
	end

endmodule
